// ==== logic/conv_data_pkg.sv ====
`default_nettype none

// numeric formats and host write word layout for the convolution engine
package conv_data_pkg;

    // row and column index width
    localparam int COORD_W = 4;

    // storage bounds of the on-chip image
    localparam int IMG_MAX_W = 16;
    localparam int IMG_MAX_H = 16;

    // sample and coefficient formats
    typedef logic signed [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;

    // 9 products of 8x8 bits fit in 20 bits
    typedef logic signed [19:0] acc_t;
    typedef logic signed [15:0] result_t;

    typedef logic [COORD_W-1:0] coord_t;

    // clamp limits of result_t, held in accumulator width
    localparam acc_t RES_MAX = 20'sd32767;
    localparam acc_t RES_MIN = -20'sd32768;

    // one kernel-row worth of image taps
    typedef struct packed {
        pixel_t left;
        pixel_t mid;
        pixel_t right;
    } pixel_row_t;

    // what a host write targets
    typedef enum logic {
        WR_PIXEL  = 1'b0,
        WR_WEIGHT = 1'b1
    } wr_kind_e;

    // pixel view of the address byte
    typedef struct packed {
        coord_t row;
        coord_t col;
    } pix_addr_t;

    // weight view, kernel indices sit in the low bits of each nibble
    typedef struct packed {
        logic [1:0] pad_row;
        logic [1:0] krow;
        logic [1:0] pad_col;
        logic [1:0] kcol;
    } wgt_addr_t;

    typedef union packed {
        pix_addr_t pix;
        wgt_addr_t wgt;
    } wr_addr_u;

    // full host word, one per strobe
    typedef struct packed {
        wr_kind_e   kind;
        wr_addr_u   addr;
        logic [7:0] data;
    } wr_cmd_t;

endpackage

`default_nettype wire

// ==== logic/conv_ctrl_pkg.sv ====
`default_nettype none

// sequencer states and the control bundle sent to the datapath
package conv_ctrl_pkg;

    // one patch walks load through check_done
    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        LOAD            = 3'd1,
        MAC0            = 3'd2,
        MAC1            = 3'd3,
        MAC2            = 3'd4,
        ACC             = 3'd5,
        UPDATE_COUNTERS = 3'd6,
        CHECK_DONE      = 3'd7
    } ctrl_state_e;

    // kernel row select values
    localparam logic [1:0] SEL_ROW0 = 2'd0;
    localparam logic [1:0] SEL_ROW1 = 2'd1;
    localparam logic [1:0] SEL_ROW2 = 2'd2;

    // control lines shared by buffer, counters and mac
    typedef struct packed {
        logic       load;
        logic       flush_acc;
        logic [1:0] mux_sel;
        logic       acc_enable;
        logic       counter_enable;
    } ctrl_bundle_t;

    // all lines quiet
    localparam ctrl_bundle_t CTRL_NONE = '0;

endpackage

`default_nettype wire

// ==== logic/conv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-patch sequencer, one state per cycle
module conv_control (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        start,
    input  wire logic                        last,
    output conv_ctrl_pkg::ctrl_bundle_t      ctrl,
    output logic                             busy,
    output logic                             done
);

    conv_ctrl_pkg::ctrl_state_e state;
    conv_ctrl_pkg::ctrl_state_e next_state;

    // state register
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= conv_ctrl_pkg::IDLE;
        else
            state <= next_state;
    end

    // next state and bundle decode
    always_comb
    begin
        // quiet bundle unless a state says otherwise
        ctrl       = conv_ctrl_pkg::CTRL_NONE;
        next_state = state;

        case (state)
            conv_ctrl_pkg::IDLE:
            begin
                // start only honoured here
                if (start)
                    next_state = conv_ctrl_pkg::LOAD;
            end

            conv_ctrl_pkg::LOAD:
            begin
                ctrl.load      = 1'b1;
                ctrl.flush_acc = 1'b1;
                next_state     = conv_ctrl_pkg::MAC0;
            end

            conv_ctrl_pkg::MAC0:
            begin
                ctrl.mux_sel = conv_ctrl_pkg::SEL_ROW0;
                next_state   = conv_ctrl_pkg::MAC1;
            end

            conv_ctrl_pkg::MAC1:
            begin
                ctrl.mux_sel = conv_ctrl_pkg::SEL_ROW1;
                next_state   = conv_ctrl_pkg::MAC2;
            end

            conv_ctrl_pkg::MAC2:
            begin
                ctrl.mux_sel = conv_ctrl_pkg::SEL_ROW2;
                next_state   = conv_ctrl_pkg::ACC;
            end

            conv_ctrl_pkg::ACC:
            begin
                // mac registers the clamped sum here
                ctrl.acc_enable = 1'b1;
                next_state      = conv_ctrl_pkg::UPDATE_COUNTERS;
            end

            conv_ctrl_pkg::UPDATE_COUNTERS:
            begin
                ctrl.counter_enable = 1'b1;
                next_state          = conv_ctrl_pkg::CHECK_DONE;
            end

            conv_ctrl_pkg::CHECK_DONE:
            begin
                // last was raised by the counter step just before
                if (last)
                    next_state = conv_ctrl_pkg::IDLE;
                else
                    next_state = conv_ctrl_pkg::LOAD;
            end

            default:
            begin
                next_state = conv_ctrl_pkg::IDLE;
            end
        endcase
    end

    // one-cycle done after the final check
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= (state == conv_ctrl_pkg::CHECK_DONE) && last;
    end

    assign busy = (state != conv_ctrl_pkg::IDLE);

    // row select only ever names one of three kernel rows
    a_mux_sel_range: assert property (
        @(posedge clk) disable iff (!rst_n) ctrl.mux_sel != 2'd3
    );

endmodule

`default_nettype wire

// ==== logic/image_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// on-chip image and kernel storage
// host writes land at the sampling edge, reads are combinational
module image_buffer #(
    parameter int IMG_W = 8
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                wr_strobe,
    input  wire conv_data_pkg::wr_cmd_t              wr_cmd,
    input  wire conv_ctrl_pkg::ctrl_bundle_t         ctrl,
    input  wire conv_data_pkg::coord_t               row,
    input  wire conv_data_pkg::coord_t               col,
    output conv_data_pkg::pixel_row_t                pixels,
    output conv_data_pkg::weight_t [2:0]             weights
);

    // pixel array at full bound, only IMG_W columns used
    conv_data_pkg::pixel_t pixel_mem [conv_data_pkg::IMG_MAX_H][conv_data_pkg::IMG_MAX_W];

    // 3x3 kernel
    conv_data_pkg::weight_t wgt_reg [3][3];

    logic pix_wr;
    logic wgt_wr;

    conv_data_pkg::coord_t rd_row;
    conv_data_pkg::coord_t col_mid;
    conv_data_pkg::coord_t col_right;

    // decode through the view chosen by kind
    assign pix_wr = wr_strobe
                 && (wr_cmd.kind == conv_data_pkg::WR_PIXEL)
                 && (int'(wr_cmd.addr.pix.col) < IMG_W);

    // kernel index 3 does not exist
    assign wgt_wr = wr_strobe
                 && (wr_cmd.kind == conv_data_pkg::WR_WEIGHT)
                 && (wr_cmd.addr.wgt.krow != 2'd3)
                 && (wr_cmd.addr.wgt.kcol != 2'd3);

    // image store
    always_ff @(posedge clk)
    begin
        if (pix_wr)
            pixel_mem[wr_cmd.addr.pix.row][wr_cmd.addr.pix.col] <= wr_cmd.data;
    end

    // kernel store, zero kernel out of reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wgt_reg <= '{default: '0};
        else if (wgt_wr)
            wgt_reg[wr_cmd.addr.wgt.krow][wr_cmd.addr.wgt.kcol] <= wr_cmd.data;
    end

    // patch row picked by the mac step
    assign rd_row    = row + {2'b00, ctrl.mux_sel};
    assign col_mid   = col + 4'd1;
    assign col_right = col + 4'd2;

    assign pixels.left  = pixel_mem[rd_row][col];
    assign pixels.mid   = pixel_mem[rd_row][col_mid];
    assign pixels.right = pixel_mem[rd_row][col_right];

    // weight index matches tap order left to right
    assign weights[0] = wgt_reg[ctrl.mux_sel][0];
    assign weights[1] = wgt_reg[ctrl.mux_sel][1];
    assign weights[2] = wgt_reg[ctrl.mux_sel][2];

    // host never addresses a column past the image width
    a_pix_col_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_strobe && (wr_cmd.kind == conv_data_pkg::WR_PIXEL))
            |-> (int'(wr_cmd.addr.pix.col) < IMG_W)
    );

endmodule

`default_nettype wire

// ==== logic/patch_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// patch origin in row-major order, no padding
module patch_counter #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire conv_ctrl_pkg::ctrl_bundle_t ctrl,
    output conv_data_pkg::coord_t            row,
    output conv_data_pkg::coord_t            col,
    output logic                             last
);

    // last valid origin on each axis
    localparam conv_data_pkg::coord_t COL_LAST = conv_data_pkg::coord_t'(IMG_W - 3);
    localparam conv_data_pkg::coord_t ROW_LAST = conv_data_pkg::coord_t'(IMG_H - 3);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row  <= '0;
            col  <= '0;
            last <= 1'b0;
        end
        else
        begin
            // stale last from a previous run dropped at first load
            if (ctrl.load)
                last <= 1'b0;

            if (ctrl.counter_enable)
            begin
                if (col == COL_LAST)
                begin
                    col <= '0;
                    if (row == ROW_LAST)
                    begin
                        // final patch done, rewind for next run
                        row  <= '0;
                        last <= 1'b1;
                    end
                    else
                    begin
                        row <= row + 1'b1;
                    end
                end
                else
                begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // origin always inside the valid-patch window
    a_origin_range: assert property (
        @(posedge clk) disable iff (!rst_n) (row <= ROW_LAST) && (col <= COL_LAST)
    );

endmodule

`default_nettype wire

// ==== logic/mac_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// three-tap row mac, 20-bit accumulate, clamp to 16 bits
module mac_unit (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire conv_ctrl_pkg::ctrl_bundle_t ctrl,
    input  wire conv_data_pkg::pixel_row_t   pixels,
    input  wire conv_data_pkg::weight_t [2:0] weights,
    output logic                             res_valid,
    output conv_data_pkg::result_t           res_data
);

    // high in the cycle after load, marks mac0
    logic load_q;
    logic mac_en;

    conv_data_pkg::acc_t acc;
    conv_data_pkg::acc_t prod_l;
    conv_data_pkg::acc_t prod_m;
    conv_data_pkg::acc_t prod_r;
    conv_data_pkg::result_t sat_val;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            load_q <= 1'b0;
        else
            load_q <= ctrl.load;
    end

    // mac states carry no other control bit
    // mux_sel 0 is shared with idle and load, so row 0 needs load_q
    assign mac_en = !ctrl.load
                 && !ctrl.acc_enable
                 && !ctrl.counter_enable
                 && ((ctrl.mux_sel != 2'd0) || load_q);

    // products widened first so sign is kept
    assign prod_l = conv_data_pkg::acc_t'(pixels.left)  * conv_data_pkg::acc_t'(weights[0]);
    assign prod_m = conv_data_pkg::acc_t'(pixels.mid)   * conv_data_pkg::acc_t'(weights[1]);
    assign prod_r = conv_data_pkg::acc_t'(pixels.right) * conv_data_pkg::acc_t'(weights[2]);

    // accumulator
    always_ff @(posedge clk)
    begin
        if (ctrl.flush_acc)
            acc <= '0;
        else if (mac_en)
            acc <= acc + prod_l + prod_m + prod_r;
    end

    // clamp to result range
    always_comb
    begin
        if (acc > conv_data_pkg::RES_MAX)
            sat_val = 16'sh7fff;
        else if (acc < conv_data_pkg::RES_MIN)
            sat_val = 16'sh8000;
        else
            sat_val = conv_data_pkg::result_t'(acc);
    end

    // result held until the next patch
    always_ff @(posedge clk)
    begin
        if (ctrl.acc_enable)
            res_data <= sat_val;
    end

    // strobe lands in the update_counters cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= ctrl.acc_enable;
    end

endmodule

`default_nettype wire

// ==== logic/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// 3x3 convolution engine top
module conv_top #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    wr_strobe,
    input  wire conv_data_pkg::wr_cmd_t  wr_cmd,
    input  wire logic                    start,
    output logic                         busy,
    output logic                         done,
    output logic                         res_valid,
    output conv_data_pkg::result_t       res_data
);

    // sequencer to datapath
    conv_ctrl_pkg::ctrl_bundle_t ctrl;

    // patch origin and end-of-image flag
    conv_data_pkg::coord_t row;
    conv_data_pkg::coord_t col;
    logic                  last;

    // current kernel row operands
    conv_data_pkg::pixel_row_t    pixels;
    conv_data_pkg::weight_t [2:0] weights;

    conv_control i_control (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .last  (last),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    patch_counter #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .row   (row),
        .col   (col),
        .last  (last)
    );

    image_buffer #(
        .IMG_W (IMG_W)
    ) i_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_strobe (wr_strobe),
        .wr_cmd    (wr_cmd),
        .ctrl      (ctrl),
        .row       (row),
        .col       (col),
        .pixels    (pixels),
        .weights   (weights)
    );

    mac_unit i_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pixels    (pixels),
        .weights   (weights),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

`default_nettype wire

// ==== verification/tb_conv.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv;

    localparam int IMG_W     = 8;
    localparam int IMG_H     = 6;
    localparam int N_PATCH   = (IMG_W - 2) * (IMG_H - 2);
    localparam int RUN_LIMIT = 300;

    // kernel bytes row-major with k0 in the top byte
    typedef struct packed {
        logic [71:0] kernel;
        logic        rand_kernel;
        logic        rand_image;
        logic [7:0]  fill;
    } stim_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    wr_strobe;
    conv_data_pkg::wr_cmd_t  wr_cmd;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    res_valid;
    conv_data_pkg::result_t  res_data;

    // count of posedges so far
    int cyc = 0;
    logic [31:0] lfsr_state;

    stim_t stim [4];

    // reference copies of what was loaded
    logic signed [7:0] img [IMG_H][IMG_W];
    logic signed [7:0] ker [3][3];
    conv_data_pkg::result_t exp_res [N_PATCH];

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    conv_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_strobe (wr_strobe),
        .wr_cmd    (wr_cmd),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value == 1'b0)
        else
            abort_run($sformatf("mismatch %s: expected %h, got %h", name, 1'b0, value));
    endtask

    // galois form with taps x^32 x^22 x^2 x 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return b;
    endfunction

    function automatic int clamp16(input int v);
        if (v > 32767)
            return 32767;
        if (v < -32768)
            return -32768;
        return v;
    endfunction

    // one host word per cycle, strobe stays up while words follow
    task automatic send_word(input conv_data_pkg::wr_cmd_t cmd);
        @(posedge clk);
        #1;
        wr_cmd    = cmd;
        wr_strobe = 1'b1;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #1;
        wr_strobe = 1'b0;
        wr_cmd    = '0;
    endtask

    task automatic load_kernel(input int r);
        conv_data_pkg::wr_cmd_t cmd;
        logic [7:0] w;
        for (int k = 0; k < 9; k++)
        begin
            w = stim[r].rand_kernel ? rand_byte() : stim[r].kernel[71 - 8 * k -: 8];
            ker[k / 3][k % 3] = w;
            cmd = '0;
            cmd.kind = conv_data_pkg::WR_WEIGHT;
            cmd.addr.wgt.krow = 2'(k / 3);
            cmd.addr.wgt.kcol = 2'(k % 3);
            cmd.data = w;
            send_word(cmd);
        end
    endtask

    task automatic load_image(input int r);
        conv_data_pkg::wr_cmd_t cmd;
        logic [7:0] v;
        for (int y = 0; y < IMG_H; y++)
        begin
            for (int x = 0; x < IMG_W; x++)
            begin
                v = stim[r].rand_image ? rand_byte() : stim[r].fill;
                img[y][x] = v;
                cmd = '0;
                cmd.kind = conv_data_pkg::WR_PIXEL;
                cmd.addr.pix.row = 4'(y);
                cmd.addr.pix.col = 4'(x);
                cmd.data = v;
                send_word(cmd);
            end
        end
    endtask

    // 9-term signed sum per patch, row-major order, clamped
    task automatic compute_expected();
        int sum;
        int n;
        n = 0;
        for (int pr = 0; pr <= IMG_H - 3; pr++)
        begin
            for (int pc = 0; pc <= IMG_W - 3; pc++)
            begin
                sum = 0;
                for (int kr = 0; kr < 3; kr++)
                    for (int kc = 0; kc < 3; kc++)
                        sum += int'(img[pr + kr][pc + kc]) * int'(ker[kr][kc]);
                exp_res[n] = conv_data_pkg::result_t'(clamp16(sum));
                n++;
            end
        end
    endtask

    // stray results or done show up as outputs that are not quiet
    task automatic check_idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            expect_low("busy", busy);
            expect_low("done", done);
            expect_low("res_valid", res_valid);
        end
    endtask

    task automatic run_row(input int r);
        int n_res;
        int start_cyc;
        int last_cyc;
        int exp_cyc;
        int wait_cnt;
        logic poked;
        logic finished;
        n_res    = 0;
        last_cyc = 0;
        wait_cnt = 0;
        poked    = 1'b0;
        finished = 1'b0;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(negedge clk);
        start_cyc = cyc;
        while (!finished)
        begin
            @(posedge clk);
            #1;
            // extra start in mac0 of the sixth patch is ignored by the sequencer
            start = (n_res == 5) && (cyc == last_cyc + 3) && !poked;
            if (start)
                poked = 1'b1;
            @(negedge clk);
            wait_cnt++;
            assert (wait_cnt < RUN_LIMIT)
            else
                abort_run($sformatf("timeout waiting for done in table row %0d", r));
            if (!done)
            begin
                assert (busy == 1'b1)
                else
                    abort_run($sformatf("mismatch busy: expected %h, got %h", 1'b1, busy));
            end
            if (res_valid)
            begin
                assert (n_res < N_PATCH)
                else
                    abort_run("more results than patches in the image");
                exp_cyc = (n_res == 0) ? start_cyc + 6 : last_cyc + 7;
                assert (cyc == exp_cyc)
                else
                    abort_run($sformatf("mismatch res_valid cycle: expected %h, got %h",
                                        exp_cyc, cyc));
                assert (res_data == exp_res[n_res])
                else
                    abort_run($sformatf("mismatch res_data[%0d]: expected %h, got %h",
                                        n_res, exp_res[n_res], res_data));
                last_cyc = cyc;
                n_res++;
            end
            if (done)
            begin
                assert (n_res == N_PATCH)
                else
                    abort_run($sformatf("mismatch result count: expected %h, got %h",
                                        N_PATCH, n_res));
                assert (cyc == last_cyc + 2)
                else
                    abort_run($sformatf("mismatch done cycle: expected %h, got %h",
                                        last_cyc + 2, cyc));
                finished = 1'b1;
            end
        end
    endtask

    initial
    begin
        rst_n      = 1'b0;
        start      = 1'b0;
        wr_strobe  = 1'b0;
        wr_cmd     = '0;
        lfsr_state = 32'h2fff_dacd;

        // identity, random kernel, positive and negative saturation
        stim[0] = '{72'h00_00_00_00_01_00_00_00_00, 1'b0, 1'b1, 8'h00};
        stim[1] = '{72'h0, 1'b1, 1'b1, 8'h00};
        stim[2] = '{72'h7f_7f_7f_7f_7f_7f_7f_7f_7f, 1'b0, 1'b0, 8'h7f};
        stim[3] = '{72'h7f_7f_7f_7f_7f_7f_7f_7f_7f, 1'b0, 1'b0, 8'h80};

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_idle(4);

        for (int r = 0; r < 4; r++)
        begin
            load_kernel(r);
            load_image(r);
            end_writes();
            compute_expected();
            run_row(r);
            check_idle(12);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/conv_data_pkg.sv
logic/conv_ctrl_pkg.sv
logic/conv_control.sv
logic/image_buffer.sv
logic/patch_counter.sv
logic/mac_unit.sv
logic/conv_top.sv
verification/tb_conv.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the convolution engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_conv -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_conv 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
